// File: rtl/tiled_pkg.sv
// tiled channel package with widths, register addresses and derived sizes
`default_nettype none

package tiled_pkg;
    localparam int addr_bits       = 15;                       // memory row address
    localparam int col_bits        = 10;                       // column address
    localparam int rc_bits         = addr_bits + col_bits - 3; // {row, col8} in 8-bursts
    localparam int page_bursts_log = 7;                        // 128 8-bursts per page
    localparam int frame_w_bits    = 13;                       // frame width in bursts
    localparam int frame_h_bits    = 16;                       // frame height in lines
    localparam int tile_w_bits     = 6;                        // tile width - 1
    localparam int tile_h_bits     = 6;                        // tile height - 1

    localparam logic [15:0] cmd_base = 16'h0120; // channel address match
    localparam logic [15:0] cmd_mask = 16'h03f0;

    localparam logic [3:0] reg_mode        = 4'h0; // {extra_pages[1:0], enable, !reset}
    localparam logic [3:0] reg_start_addr  = 4'h2; // frame start, {row, col8}
    localparam logic [3:0] reg_full_width  = 4'h3; // padded line width in 8-bursts
    localparam logic [3:0] reg_window_wh   = 4'h4; // {height, width}, 0 means max
    localparam logic [3:0] reg_window_x0y0 = 4'h5; // {top, left}
    localparam logic [3:0] reg_tile_wh     = 4'h7; // {tile height, tile width}

    localparam int recalc_stages = 7;                       // recalculation chain length
    localparam int buf_pages     = 4;                       // on-chip buffer pages
    localparam int page_bits     = $clog2(buf_pages + 1);   // free page counter width
    localparam int pend_bits     = 2;                       // outstanding transfers
endpackage

`default_nettype wire

// File: rtl/cmd_deser.sv
// byte-serial command deserializer producing a 4-bit address, 32-bit data and write pulse
`timescale 1ns/1ps
`default_nettype none

module cmd_deser import tiled_pkg::*; (
    input  wire         rst,      // clock
    input  wire         mclk,     // async reset
    input  wire  [7:0]  cmd_ad,
    input  wire         cmd_stb,  // with address low byte
    output logic [3:0]  cmd_a,
    output logic [31:0] cmd_data,
    output logic        cmd_we
);
    logic [47:0] sr;    // {d3, d2, d1, d0, ah, al} once complete
    logic [2:0]  cnt;   // bytes received so far, 0 when idle
    logic        match;

    // at the sixth byte, al/ah sit one byte above their final place
    assign match    = ((sr[23:8] ^ cmd_base) & cmd_mask) == 16'h0;
    assign cmd_a    = sr[3:0];
    assign cmd_data = sr[47:16];

    always_ff @(posedge rst) begin
        if (cmd_stb || cnt != 3'd0) begin
            sr <= {cmd_ad, sr[47:8]}; // shift in from the top
        end
    end

    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) begin
            cnt    <= 3'd0;
            cmd_we <= 1'b0;
        end else begin
            if (cmd_stb) begin
                cnt <= 3'd1;
            end else if (cnt == 3'd5) begin
                cnt <= 3'd0;            // last data byte arrives now
            end else if (cnt != 3'd0) begin
                cnt <= cnt + 3'd1;
            end
            cmd_we <= (cnt == 3'd5) && !cmd_stb && match;
        end
    end
endmodule

`default_nettype wire

// File: rtl/tile_param_regs.sv
// programmed frame, window, tile and mode registers of the tiled read channel
`timescale 1ns/1ps
`default_nettype none

module tile_param_regs import tiled_pkg::*; (
    input  wire                      rst,
    input  wire                      mclk,
    input  wire  [3:0]               cmd_a,
    input  wire  [31:0]              cmd_data,
    input  wire                      cmd_we,
    output logic                     chn_en,      // requests allowed
    output logic                     chn_rst,     // channel held in reset
    output logic [1:0]               extra_pages,
    output logic [rc_bits-1:0]       start_addr,
    output logic [frame_w_bits:0]    full_width,
    output logic [frame_w_bits:0]    window_w,
    output logic [frame_h_bits:0]    window_h,
    output logic [frame_w_bits-1:0]  window_x0,
    output logic [frame_h_bits-1:0]  window_y0,
    output logic [tile_w_bits:0]     tile_cols,   // full count, 0 -> 64
    output logic [tile_h_bits:0]     tile_rows
);
    logic [3:0] mode;
    logic       lo_zero, hi_zero, tw_zero, th_zero;

    assign lo_zero = cmd_data[frame_w_bits-1:0] == '0;        // zero width -> max
    assign hi_zero = cmd_data[frame_h_bits+15:16] == '0;
    assign tw_zero = cmd_data[tile_w_bits-1:0] == '0;
    assign th_zero = cmd_data[tile_h_bits+15:16] == '0;

    assign chn_en      = &mode[1:0]; // enable only counts when out of reset
    assign chn_rst     = ~mode[0];
    assign extra_pages = mode[3:2];

    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) begin
            mode       <= '0;
            start_addr <= '0;
            full_width <= '0;
            window_w   <= '0;
            window_h   <= '0;
            window_x0  <= '0;
            window_y0  <= '0;
            tile_cols  <= '0;
            tile_rows  <= '0;
        end else if (cmd_we) begin
            case (cmd_a)
                reg_mode:        mode       <= cmd_data[3:0];
                reg_start_addr:  start_addr <= cmd_data[rc_bits-1:0];
                reg_full_width:  full_width <= {lo_zero, cmd_data[frame_w_bits-1:0]};
                reg_window_wh: begin
                    window_w <= {lo_zero, cmd_data[frame_w_bits-1:0]};
                    window_h <= {hi_zero, cmd_data[frame_h_bits+15:16]};
                end
                reg_window_x0y0: begin
                    window_x0 <= cmd_data[frame_w_bits-1:0];
                    window_y0 <= cmd_data[frame_h_bits+15:16];
                end
                reg_tile_wh: begin
                    tile_cols <= {tw_zero, cmd_data[tile_w_bits-1:0]};
                    tile_rows <= {th_zero, cmd_data[tile_h_bits+15:16]};
                end
                default: ; // unused addresses ignored
            endcase
        end
    end
endmodule

`default_nettype wire

// File: rtl/tile_geometry.sv
// four-stage recalculation of tile position, row and page remainders and transfer width
`timescale 1ns/1ps
`default_nettype none

module tile_geometry import tiled_pkg::*; (
    input  wire                      rst,         // clock
    input  wire  [recalc_stages-1:0] recalc,      // one-hot stage enables
    input  wire  [frame_w_bits-1:0]  curr_x,      // relative to window
    input  wire  [frame_h_bits-1:0]  curr_y,
    input  wire                      continued,   // second half of a split tile
    input  wire  [frame_w_bits:0]    window_w,
    input  wire  [frame_h_bits:0]    window_h,
    input  wire  [frame_w_bits-1:0]  window_x0,
    input  wire  [frame_h_bits-1:0]  window_y0,
    input  wire  [tile_w_bits:0]     tile_cols,
    input  wire  [tile_h_bits:0]     tile_rows,
    output logic [frame_w_bits-1:0]  frame_x,
    output logic [frame_h_bits-1:0]  frame_y,
    output logic [frame_h_bits:0]    next_y,
    output logic [tile_w_bits:0]     num_cols,
    output logic                     partial,
    output logic                     last_in_row,
    output logic                     last_row,
    output logic [tile_w_bits-1:0]   num_cols_m1,
    output logic [tile_h_bits-1:0]   num_rows_m1
);
    localparam int pad_pg = page_bursts_log - tile_w_bits; // tile width to page width

    logic [frame_w_bits:0]      row_left;  // bursts left in the window row
    logic [page_bursts_log:0]   page_left; // bursts left in the memory page
    logic [tile_w_bits:0]       lim_w;     // width limited by tile and row
    logic [tile_w_bits-1:0]     leftover;  // columns for the continued half
    logic                       by_page;
    logic [page_bursts_log:0]   remainder;
    logic [tile_w_bits:0]       cols_m1, rows_m1;

    assign by_page     = page_left < {{pad_pg{1'b0}}, lim_w};
    assign remainder   = {{pad_pg{1'b0}}, lim_w} - page_left;
    assign last_row    = next_y >= window_h;
    assign cols_m1     = num_cols - {{tile_w_bits{1'b0}}, 1'b1};
    assign rows_m1     = tile_rows - {{tile_h_bits{1'b0}}, 1'b1};
    assign num_cols_m1 = cols_m1[tile_w_bits-1:0];  // 64 -> 63 fits
    assign num_rows_m1 = rows_m1[tile_h_bits-1:0];

    always_ff @(posedge rst) begin
        if (recalc[0]) begin
            frame_x  <= curr_x + window_x0;
            frame_y  <= curr_y + window_y0;
            next_y   <= {1'b0, curr_y} + {{(frame_h_bits-tile_h_bits){1'b0}}, tile_rows};
            row_left <= window_w - {1'b0, curr_x};
        end
        if (recalc[1]) begin
            page_left <= {1'b1, {page_bursts_log{1'b0}}}
                       - {1'b0, frame_x[page_bursts_log-1:0]};
            lim_w <= (|row_left[frame_w_bits:tile_w_bits] ||
                      row_left[tile_w_bits:0] >= tile_cols) ? tile_cols
                                                            : row_left[tile_w_bits:0];
        end
        if (recalc[2]) begin
            partial  <= by_page && !continued; // a continued half never splits again
            leftover <= remainder[tile_w_bits-1:0];
            if (continued) begin
                num_cols <= {1'b0, leftover};
            end else begin
                num_cols <= by_page ? page_left[tile_w_bits:0] : lim_w;
            end
        end
        if (recalc[3]) begin
            last_in_row <= row_left == {{(frame_w_bits-tile_w_bits){1'b0}}, num_cols};
        end
    end
endmodule

`default_nettype wire

// File: rtl/line_addr_calc.sv
// registered multiply-add giving the row/column burst address and bank of the current tile
`timescale 1ns/1ps
`default_nettype none

module line_addr_calc import tiled_pkg::*; (
    input  wire                      rst,        // clock
    input  wire  [recalc_stages-1:0] recalc,
    input  wire  [frame_w_bits-1:0]  frame_x,
    input  wire  [frame_h_bits-1:0]  frame_y,
    input  wire  [rc_bits-1:0]       start_addr,
    input  wire  [frame_w_bits:0]    full_width,
    output logic [2:0]               xfer_bank,
    output logic [addr_bits-1:0]     xfer_row,
    output logic [page_bursts_log-1:0] xfer_col
);
    logic [frame_h_bits-4:0]           fy8_r;      // line / 8, bank stripped
    logic [frame_w_bits:0]             fw_r;
    logic [rc_bits-1:0]                sa_r;
    logic [frame_h_bits+frame_w_bits-3:0] prod;
    logic [rc_bits-1:0]                mul_r;
    logic [rc_bits-1:0]                line_start; // first burst of the line
    logic [rc_bits-1:0]                row_col;

    assign prod     = fy8_r * fw_r;               // upper bits fall off
    assign xfer_row = row_col[rc_bits-1:page_bursts_log];
    assign xfer_col = row_col[page_bursts_log-1:0];

    always_ff @(posedge rst) begin
        fy8_r      <= frame_y[frame_h_bits-1:3]; // free-running multiplier operands
        fw_r       <= full_width;
        sa_r       <= start_addr;
        mul_r      <= prod[rc_bits-1:0];
        line_start <= sa_r + mul_r;              // settled by stage 5
        if (recalc[5]) begin
            row_col   <= line_start + {{(rc_bits-frame_w_bits){1'b0}}, frame_x};
            xfer_bank <= frame_y[2:0];           // line mod 8
        end
    end
endmodule

`default_nettype wire

// File: rtl/tiled_ctrl.sv
// tiled channel control: walk position, buffer page and pending counters, request and done
`timescale 1ns/1ps
`default_nettype none

module tiled_ctrl import tiled_pkg::*; (
    input  wire                      rst,           // clock
    input  wire                      mclk,          // async reset
    input  wire                      cmd_we,
    input  wire                      chn_en,
    input  wire                      chn_rst,
    input  wire  [1:0]               extra_pages,
    input  wire                      frame_start,
    input  wire                      next_page,     // consumer freed a buffer page
    input  wire                      xfer_grant,
    input  wire                      xfer_page_done,
    input  wire  [tile_w_bits:0]     num_cols,
    input  wire                      partial,
    input  wire                      last_in_row,
    input  wire                      last_row,
    input  wire  [frame_h_bits:0]    next_y,
    output logic [recalc_stages-1:0] recalc,
    output logic [frame_w_bits-1:0]  curr_x,
    output logic [frame_h_bits-1:0]  curr_y,
    output logic                     continued,
    output logic                     xfer_want,
    output logic                     xfer_need,
    output logic                     xfer_start,
    output logic                     xfer_page_rst,
    output logic                     frame_done
);
    logic [recalc_stages-1:0] valid_sr;   // fills with ones after a change
    logic                     calc_valid;
    logic                     chn_rst_d;
    logic                     busy;
    logic                     last_block; // final tile already issued
    logic                     pre_want;
    logic                     start_full; // start that fills a buffer page
    logic [page_bits-1:0]     page_cntr;  // free buffer pages
    logic [pend_bits-1:0]     pending;    // started, page not done yet

    assign calc_valid = valid_sr[recalc_stages-1];
    assign start_full = xfer_start && !partial;
    assign pre_want   = chn_en && busy && !xfer_want && !xfer_start && calc_valid && !last_block;

    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) begin
            valid_sr      <= '0;
            recalc        <= '0;
            chn_rst_d     <= 1'b0;
            busy          <= 1'b0;
            xfer_start    <= 1'b0;
            continued     <= 1'b0;
            xfer_want     <= 1'b0;
            xfer_need     <= 1'b0;
            page_cntr     <= '0;
            xfer_page_rst <= 1'b1;
            curr_x        <= '0;
            curr_y        <= '0;
            last_block    <= 1'b0;
            pending       <= '0;
            frame_done    <= 1'b0;
        end else begin
            if (cmd_we || xfer_start || frame_start || chn_rst) begin
                valid_sr <= '0;
            end else begin
                valid_sr <= {valid_sr[recalc_stages-2:0], 1'b1};
            end
            chn_rst_d <= chn_rst;
            if (chn_rst) begin
                recalc <= '0;
            end else begin // chn_rst_d here marks leaving reset
                recalc <= {recalc[recalc_stages-2:0],
                           xfer_start | frame_start | cmd_we | chn_rst_d};
            end

            if (chn_rst)          busy <= 1'b0;
            else if (frame_start) busy <= 1'b1;
            else if (frame_done)  busy <= 1'b0;

            xfer_start    <= xfer_grant && !chn_rst;
            xfer_page_rst <= chn_rst;

            if (chn_rst || frame_start) continued <= 1'b0;
            else if (xfer_start)        continued <= partial; // leftover goes next

            if (chn_rst || xfer_grant) begin
                xfer_want <= 1'b0;
                xfer_need <= 1'b0;
            end else begin
                if (pre_want && page_cntr > page_bits'(extra_pages)) xfer_want <= 1'b1;
                if (pre_want && page_cntr >= page_bits'(3))          xfer_need <= 1'b1;
            end

            if (frame_start)                   page_cntr <= page_bits'(buf_pages);
            else if (start_full && !next_page) page_cntr <= page_cntr - 1'b1;
            else if (!start_full && next_page) page_cntr <= page_cntr + 1'b1;

            if (chn_rst || frame_start) begin
                curr_x <= '0;
                curr_y <= '0;
            end else if (xfer_start) begin
                curr_x <= last_in_row ? '0
                        : curr_x + {{(frame_w_bits-tile_w_bits-1){1'b0}}, num_cols};
                if (last_in_row) curr_y <= next_y[frame_h_bits-1:0];
            end

            if (chn_rst || !busy)                          last_block <= 1'b0;
            else if (xfer_start && last_in_row && last_row) last_block <= 1'b1;

            if (chn_rst || !busy)                        pending <= '0;
            else if (start_full && !xfer_page_done)      pending <= pending + 1'b1;
            else if (!start_full && xfer_page_done)      pending <= pending - 1'b1;

            // the last page done empties the pending count
            frame_done <= busy && last_block && xfer_page_done && !start_full
                       && pending == pend_bits'(1);
        end
    end
endmodule

`default_nettype wire

// File: rtl/tiled_rw.sv
// tiled-order DDR3 read channel top with command port, geometry, address and control
`timescale 1ns/1ps
`default_nettype none

module tiled_rw import tiled_pkg::*; (
    input  wire                        rst,          // clock
    input  wire                        mclk,         // async reset
    input  wire  [7:0]                 cmd_ad,
    input  wire                        cmd_stb,
    input  wire                        frame_start,
    input  wire                        next_page,
    input  wire                        xfer_grant,
    input  wire                        xfer_page_done,
    output wire                        xfer_want,
    output wire                        xfer_need,
    output wire                        xfer_start,
    output wire  [2:0]                 xfer_bank,
    output wire  [addr_bits-1:0]       xfer_row,
    output wire  [page_bursts_log-1:0] xfer_col,
    output wire  [frame_w_bits:0]      rowcol_inc,   // next line step in 8-bursts
    output wire  [tile_h_bits-1:0]     num_rows_m1,
    output wire  [tile_w_bits-1:0]     num_cols_m1,
    output wire                        xfer_partial, // first half of a split tile
    output wire                        xfer_page_rst,
    output wire                        frame_done
);
    wire [3:0]               cmd_a;
    wire [31:0]              cmd_data;
    wire                     cmd_we;
    wire                     chn_en, chn_rst;
    wire [1:0]               extra_pages;
    wire [rc_bits-1:0]       start_addr;
    wire [frame_w_bits:0]    full_width, window_w;
    wire [frame_h_bits:0]    window_h, next_y;
    wire [frame_w_bits-1:0]  window_x0, curr_x, frame_x;
    wire [frame_h_bits-1:0]  window_y0, curr_y, frame_y;
    wire [tile_w_bits:0]     tile_cols, num_cols;
    wire [tile_h_bits:0]     tile_rows;
    wire [recalc_stages-1:0] recalc;
    wire                     continued, last_in_row, last_row;

    assign rowcol_inc = full_width;

    cmd_deser u_deser (
        .rst(rst), .mclk(mclk), .cmd_ad(cmd_ad), .cmd_stb(cmd_stb),
        .cmd_a(cmd_a), .cmd_data(cmd_data), .cmd_we(cmd_we)
    );

    tile_param_regs u_regs (
        .rst(rst), .mclk(mclk), .cmd_a(cmd_a), .cmd_data(cmd_data), .cmd_we(cmd_we),
        .chn_en(chn_en), .chn_rst(chn_rst), .extra_pages(extra_pages),
        .start_addr(start_addr), .full_width(full_width),
        .window_w(window_w), .window_h(window_h),
        .window_x0(window_x0), .window_y0(window_y0),
        .tile_cols(tile_cols), .tile_rows(tile_rows)
    );

    tile_geometry u_geom (
        .rst(rst), .recalc(recalc), .curr_x(curr_x), .curr_y(curr_y),
        .continued(continued), .window_w(window_w), .window_h(window_h),
        .window_x0(window_x0), .window_y0(window_y0),
        .tile_cols(tile_cols), .tile_rows(tile_rows),
        .frame_x(frame_x), .frame_y(frame_y), .next_y(next_y),
        .num_cols(num_cols), .partial(xfer_partial),
        .last_in_row(last_in_row), .last_row(last_row),
        .num_cols_m1(num_cols_m1), .num_rows_m1(num_rows_m1)
    );

    line_addr_calc u_addr (
        .rst(rst), .recalc(recalc), .frame_x(frame_x), .frame_y(frame_y),
        .start_addr(start_addr), .full_width(full_width),
        .xfer_bank(xfer_bank), .xfer_row(xfer_row), .xfer_col(xfer_col)
    );

    tiled_ctrl u_ctrl (
        .rst(rst), .mclk(mclk), .cmd_we(cmd_we),
        .chn_en(chn_en), .chn_rst(chn_rst), .extra_pages(extra_pages),
        .frame_start(frame_start), .next_page(next_page),
        .xfer_grant(xfer_grant), .xfer_page_done(xfer_page_done),
        .num_cols(num_cols), .partial(xfer_partial),
        .last_in_row(last_in_row), .last_row(last_row), .next_y(next_y),
        .recalc(recalc), .curr_x(curr_x), .curr_y(curr_y), .continued(continued),
        .xfer_want(xfer_want), .xfer_need(xfer_need), .xfer_start(xfer_start),
        .xfer_page_rst(xfer_page_rst), .frame_done(frame_done)
    );
endmodule

`default_nettype wire

// File: tests/tiled_rw_tests.svh
// directed tests and reference tile walk model for the tiled read channel testbench
`ifndef tiled_rw_tests_svh
`define tiled_rw_tests_svh

logic [37:0] exp_q[$];   // {partial, rows_m1, cols_m1, bank, row, col} in walk order
int cfg_sa, cfg_fw, cfg_ww, cfg_wh, cfg_x0, cfg_y0, cfg_tc, cfg_tr;

task automatic write_reg(input logic [3:0] a, input logic [31:0] d);
    logic [47:0] bytes;
    bytes = {d, 8'h01, 4'h2, a}; // address 0x0120 + a sent low byte first
    for (int i = 0; i < 6; i++) begin
        @(negedge rst);
        cmd_ad  = bytes[8*i +: 8];
        cmd_stb = (i == 0);
    end
    @(negedge rst);
    cmd_stb = 1'b0;
    cmd_ad  = 8'h00;
    repeat (2) @(negedge rst); // write pulse and register load
endtask

task automatic setup(input int sa, fw, ww, wh, x0, y0, tc, tr, input logic [3:0] mode);
    cfg_sa = sa;
    cfg_fw = fw;
    cfg_ww = ww;
    cfg_wh = wh;
    cfg_x0 = x0;
    cfg_y0 = y0;
    cfg_tc = tc;
    cfg_tr = tr;
    write_reg(reg_mode, 32'h0);  // channel reset clears counters
    write_reg(reg_start_addr, sa);
    write_reg(reg_full_width, fw);
    write_reg(reg_window_wh, {wh[15:0], ww[15:0]});
    write_reg(reg_window_x0y0, {y0[15:0], x0[15:0]});
    write_reg(reg_tile_wh, {tr[15:0], tc[15:0]});
    write_reg(reg_mode, {28'h0, mode});
    @(negedge rst);
    frame_start = 1'b1;
    @(negedge rst);
    frame_start = 1'b0;
endtask

function automatic logic [37:0] entry(input int fx, fy, cols, input logic part);
    logic [31:0] rc;
    rc = (cfg_sa + (fy / 8) * cfg_fw + fx) & 32'h3fffff; // 22-bit {row, col}
    return {part, 6'(cfg_tr - 1), 6'(cols - 1), 3'(fy % 8), rc[21:7], rc[6:0]};
endfunction

// walk left to right, then down by tile height; split at 128-burst pages
task automatic build_walk();
    int x, y, fx, lim, pl;
    exp_q.delete();
    x = 0;
    y = 0;
    forever begin
        fx  = cfg_x0 + x;
        lim = (cfg_ww - x < cfg_tc) ? cfg_ww - x : cfg_tc;
        pl  = 128 - fx % 128;
        if (pl < lim) begin
            exp_q.push_back(entry(fx, cfg_y0 + y, pl, 1'b1));
            exp_q.push_back(entry(fx + pl, cfg_y0 + y, lim - pl, 1'b0));
        end else begin
            exp_q.push_back(entry(fx, cfg_y0 + y, lim, 1'b0));
        end
        x += lim;
        if (x >= cfg_ww) begin
            if (y + cfg_tr >= cfg_wh) break;
            x = 0;
            y += cfg_tr;
        end
    end
endtask

task automatic wait_want(input int limit, output bit seen);
    seen = 1'b0;
    for (int i = 0; i < limit && !seen; i++) begin
        @(negedge rst);
        seen = xfer_want;
    end
endtask

// grant the first n model transfers and answer each full one
task automatic serve(input int n, input bit give_pages);
    logic [37:0] e;
    bit          seen;
    for (int k = 0; k < n; k++) begin
        e = exp_q[k];
        wait_want(40, seen);
        if (!seen) begin
            report_failure($sformatf("no xfer_want came for transfer %0d", k));
            return;
        end
        xfer_grant = 1'b1;
        @(negedge rst);
        xfer_grant = 1'b0;
        check("xfer_start", 1, xfer_start);
        check("xfer_partial", e[37], xfer_partial);
        check("num_rows_m1", e[36:31], num_rows_m1);
        check("num_cols_m1", e[30:25], num_cols_m1);
        check("xfer_bank", e[24:22], xfer_bank);
        check("xfer_row", e[21:7], xfer_row);
        check("xfer_col", e[6:0], xfer_col);
        if (!e[37]) begin
            @(negedge rst);
            xfer_page_done = 1'b1;
            next_page      = give_pages;
            @(negedge rst);
            xfer_page_done = 1'b0;
            next_page      = 1'b0;
        end
    end
endtask

// called right after the last page done of a frame
task automatic check_frame_done(input int d0);
    check("frame_done before last page done", d0, done_count);
    check("frame_done", 1, frame_done);
    repeat (20) @(negedge rst);
    check("frame_done pulses", d0 + 1, done_count);
endtask

task automatic watch_no_want(input int n, output bit seen);
    seen = 1'b0;
    repeat (n) begin
        @(negedge rst);
        if (xfer_want) seen = 1'b1;
    end
endtask

task automatic test_reset_idle();
    bit seen;
    begin_test("reset_idle");
    check("xfer_want after reset", 0, xfer_want);
    check("xfer_start after reset", 0, xfer_start);
    check("frame_done after reset", 0, frame_done);
    check("xfer_page_rst after reset", 1, xfer_page_rst);
    setup(32'h100, 64, 16, 8, 0, 0, 8, 4, 4'b0001); // out of reset but not enabled
    watch_no_want(40, seen);
    check("xfer_want while disabled", 0, seen);
    check("starts while disabled", 0, start_count);
    check("xfer_page_rst out of reset", 0, xfer_page_rst);
    end_test();
endtask

task automatic test_single_tile();
    int sa, fw, x0, y0, d0;
    bit seen;
    begin_test("single_tile");
    sa = $random(seed) & 32'h3fffff;
    fw = 16 + ($random(seed) & 32'hff);
    x0 = $random(seed) & 32'h3f;  // stays inside one page
    y0 = $random(seed) & 32'hfff;
    setup(sa, fw, 8, 4, x0, y0, 8, 4, 4'b0011);
    check("rowcol_inc", fw, rowcol_inc); // line step equals the padded width
    build_walk();
    d0 = done_count;
    wait_want(40, seen);
    check("xfer_want", 1, seen);
    check("xfer_need with all pages free", 1, xfer_need);
    serve(1, 1'b1);
    check_frame_done(d0);
    end_test();
endtask

task automatic test_tile_walk();
    int d0;
    begin_test("tile_walk");
    setup(32'h1000, 40, 20, 12, 3, 5, 8, 4, 4'b0011); // 8+8+4 wide in three tile rows
    build_walk();
    d0 = done_count;
    serve(exp_q.size(), 1'b1);
    check_frame_done(d0);
    end_test();
endtask

task automatic test_page_split();
    int d0;
    begin_test("page_split");
    setup(32'h200, 128, 16, 2, 120, 9, 16, 2, 4'b0011); // crosses at burst 128
    build_walk();
    d0 = done_count;
    serve(2, 1'b1);
    check_frame_done(d0);
    end_test();
endtask

task automatic test_page_budget();
    bit seen;
    begin_test("page_budget");
    setup(32'h0, 128, 64, 8, 0, 0, 8, 8, 4'b0111); // one extra page held back
    build_walk();
    serve(buf_pages - 1, 1'b0);
    watch_no_want(40, seen);
    check("xfer_want with no free page", 0, seen);
    @(negedge rst);
    next_page = 1'b1;
    @(negedge rst);
    next_page = 1'b0;
    wait_want(20, seen);
    check("xfer_want after next_page", 1, seen);
    check("xfer_need with two free pages", 0, xfer_need);
    end_test();
endtask

task automatic test_channel_reset();
    bit seen;
    int s0;
    begin_test("channel_reset");
    setup(32'h0, 128, 64, 8, 0, 0, 8, 8, 4'b0011);
    build_walk();
    serve(2, 1'b1);
    wait_want(40, seen);
    check("xfer_want before reset", 1, seen);
    check("xfer_page_rst before reset", 0, xfer_page_rst);
    write_reg(reg_mode, 32'h2); // enable kept with not-reset cleared
    check("xfer_want in reset", 0, xfer_want);
    check("xfer_need in reset", 0, xfer_need);
    check("xfer_page_rst in reset", 1, xfer_page_rst);
    s0 = start_count;
    watch_no_want(40, seen);
    check("xfer_want later in reset", 0, seen);
    xfer_grant = 1'b1; // a stray grant must not start a transfer
    @(negedge rst);
    xfer_grant = 1'b0;
    repeat (4) @(negedge rst);
    check("starts in reset", s0, start_count);
    end_test();
endtask

`endif

// File: tests/tiled_rw_tb.sv
// testbench top for the tiled read channel with clock, reset, DUT, timeout and test sequence
`timescale 1ns/1ps
`default_nettype none

module tiled_rw_tb import tiled_pkg::*; ();
    localparam int max_cycles = 20000; // six setups and about twenty transfers fit many times

    logic                       rst;            // clock
    logic                       mclk;           // reset, active high
    logic [7:0]                 cmd_ad;
    logic                       cmd_stb;
    logic                       frame_start;
    logic                       next_page;
    logic                       xfer_grant;
    logic                       xfer_page_done;
    wire                        xfer_want;
    wire                        xfer_need;
    wire                        xfer_start;
    wire  [2:0]                 xfer_bank;
    wire  [addr_bits-1:0]       xfer_row;
    wire  [page_bursts_log-1:0] xfer_col;
    wire  [frame_w_bits:0]      rowcol_inc;
    wire  [tile_h_bits-1:0]     num_rows_m1;
    wire  [tile_w_bits-1:0]     num_cols_m1;
    wire                        xfer_partial;
    wire                        xfer_page_rst;
    wire                        frame_done;

    integer seed = 32'h31b1;   // test value generator state
    int     cycles;
    int     errors;
    int     checks;
    int     tests;
    int     test_err0;         // error count when the current test began
    int     start_count;       // xfer_start pulses seen
    int     done_count;        // frame_done pulses seen
    string  cur_test;

    tiled_rw dut (
        .rst(rst), .mclk(mclk), .cmd_ad(cmd_ad), .cmd_stb(cmd_stb),
        .frame_start(frame_start), .next_page(next_page),
        .xfer_grant(xfer_grant), .xfer_page_done(xfer_page_done),
        .xfer_want(xfer_want), .xfer_need(xfer_need), .xfer_start(xfer_start),
        .xfer_bank(xfer_bank), .xfer_row(xfer_row), .xfer_col(xfer_col),
        .rowcol_inc(rowcol_inc), .num_rows_m1(num_rows_m1), .num_cols_m1(num_cols_m1),
        .xfer_partial(xfer_partial), .xfer_page_rst(xfer_page_rst), .frame_done(frame_done)
    );

    initial begin
        rst = 1'b0;
        forever #4 rst = ~rst; // 8 ns period
    end

    // event counters and run limit
    always @(posedge rst) begin
        cycles++;
        if (xfer_start) start_count++;
        if (frame_done) done_count++;
        if (cycles >= max_cycles) begin
            $display("timeout: the run did not finish within %0d cycles", max_cycles);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("** Error: %s: %s expected %0h actual %0h", cur_test, what, exp, act);
        end
    endtask

    task automatic report_failure(input string msg);
        errors++;
        $display("%s: %s", cur_test, msg);
    endtask

    task automatic begin_test(input string name);
        cur_test  = name;
        test_err0 = errors;
    endtask

    task automatic end_test();
        tests++;
        if (errors == test_err0) $display("%s: ok", cur_test);
        else $display("%s: failed with %0d errors", cur_test, errors - test_err0);
    endtask

    `include "tiled_rw_tests.svh"

    initial begin
        mclk           = 1'b1;
        cmd_ad         = 8'h00;
        cmd_stb        = 1'b0;
        frame_start    = 1'b0;
        next_page      = 1'b0;
        xfer_grant     = 1'b0;
        xfer_page_done = 1'b0;
        repeat (4) @(posedge rst);
        @(negedge rst);
        mclk = 1'b0;
        test_reset_idle();
        test_single_tile();
        test_tile_walk();
        test_page_split();
        test_page_budget();
        test_channel_reset();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end
endmodule

`default_nettype wire

// File: build.f
+incdir+tests
rtl/tiled_pkg.sv
rtl/cmd_deser.sv
rtl/tile_param_regs.sv
rtl/tile_geometry.sv
rtl/line_addr_calc.sv
rtl/tiled_ctrl.sv
rtl/tiled_rw.sv
tests/tiled_rw_tb.sv

// File: Makefile
# Verilator build and run of the tiled read channel testbench

VERILATOR ?= verilator
TOP       ?= tiled_rw_tb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

SRCS := $(shell grep -v '^+' build.f) tests/tiled_rw_tests.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: $(BIN)

$(BIN): $(SRCS) build.f
	$(VERILATOR) $(VFLAGS) -f build.f --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) > $(LOG); status=$$?; cat $(LOG); exit $$status

check: run
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
